/* project.f */
+incdir+logic
logic/mem_port_pkg.sv
logic/frame_pkg.sv
logic/rd_frame_fsm.sv
logic/rd_burst_counter.sv
logic/rd_cmd_gen.sv
logic/rd_data_mover.sv
logic/back_fifo.sv
logic/frame_rd_top.sv
testbench/tb_mem_port_model.sv
testbench/tb_frame_rd.sv

/* Makefile */
# Verilator build and run of the frame buffer read side testbench.
# A failing run ends in $fatal, so make returns a failing status.

VERILATOR ?= verilator
TOP       ?= tb_frame_rd
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_frame_rd.sv */
/* Testbench for the frame buffer read side. Runs frames with several write
   pointers against the behavioral MCB port, checks the arbiter handshake,
   the read pointer, every read command and every back buffer word. */
`timescale 1ns/1ps
`include "frame_rd_defines.svh"

module tb_frame_rd import mem_port_pkg::*, frame_pkg::*; ();

	localparam int DW          = `FR_DATA_WIDTH;
	localparam int FRAME_WORDS = 256;     // 16 bursts per frame
	localparam int WAIT_LIMIT  = 20000;   // Clocks allowed per wait

	logic          clk;
	logic          i_rst;
	logic          i_start_frame;
	frame_ptr_t    i_frame_depth;
	frame_ptr_t    i_wr_frame_ptr;
	logic [15:0]   i_frame_words;
	logic          i_calib_done;
	logic          i_rd_ack;
	logic          o_rd_req;
	logic          o_reading;
	frame_ptr_t    o_rd_frame_ptr;
	logic          o_frame_done;
	logic          i_cmd_full;
	logic          o_cmd_en;
	port_cmd_t     o_cmd;
	port_rd_t      i_port_rd;
	logic [DW-1:0] i_port_data;
	logic          o_port_rd_en;
	logic          i_buf_rd_en;
	buf_word_t     o_buf_dout;
	logic          o_buf_empty;
	logic          o_buf_pe;

	frame_ptr_t exp_ptr_q [$];   // Expected frame of each frame still unread
	int         word_idx;        // Index of the next word within its frame
	int         done_count;      // o_frame_done pulses seen
	int         frames_started;
	int         duty;            // Consumer pop chance in percent
	frame_ptr_t cmd_ptr;         // Expected frame of the commands now issued
	int         cmd_idx;         // Burst index of the next command

	frame_rd_top UUT (.*);

	tb_mem_port_model port_model (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_cmd_en   (o_cmd_en),
		.i_cmd      (o_cmd),
		.i_rd_en    (o_port_rd_en),
		.o_cmd_full (i_cmd_full),
		.o_port_rd  (i_port_rd),
		.o_data     (i_port_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// Reference and checks
	// --------------------
	function automatic buf_word_t expected_word(frame_ptr_t ptr, int idx);
		buf_word_t w;
		w.data = (DW'(ptr) << `FR_FRAME_SHIFT) + DW'(idx) * 4;   // Frame base plus byte offset
		w.eof  = (idx == FRAME_WORDS - 1);
		return w;
	endfunction

	function automatic frame_ptr_t expected_ptr(frame_ptr_t wr, frame_ptr_t depth);
		if (wr == '0)
			return depth;                        // Wrap to the top frame
		return frame_ptr_t'(int'(wr) - 1);
	endfunction

	// One read of a whole burst, starting at its first word's byte address
	function automatic port_cmd_t expected_cmd(frame_ptr_t ptr, int burst);
		port_cmd_t c;
		c.instr          = CMD_READ;
		c.bl             = 6'(`FR_BURST_LEN - 1);
		c.addr.byte_addr = (ADDR_W'(ptr) << `FR_FRAME_SHIFT)
			+ ADDR_W'(burst * `FR_BURST_LEN * 4);
		return c;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input buf_word_t got, input buf_word_t exp);
		if (got !== exp)
			report_failure($sformatf("[FAIL] o_buf_dout got %h expected %h", got, exp));
	endtask

	task automatic check_ptr(input frame_ptr_t got, input frame_ptr_t exp);
		if (got !== exp)
			report_failure($sformatf("[FAIL] o_rd_frame_ptr got %h expected %h", got, exp));
	endtask

	task automatic check_cmd(input port_cmd_t got, input port_cmd_t exp);
		if (got !== exp)
			report_failure($sformatf("[FAIL] o_cmd got %h expected %h", got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	// --------------------
	// Arbiter and consumer
	// --------------------
	always @(posedge clk) begin
		if (i_rst)
			i_rd_ack <= 1'b0;
		else if (o_rd_req && ($urandom % 3) == 0)
			i_rd_ack <= 1'b1;                    // Grant after a random wait
		else if (!o_rd_req && !o_reading)
			i_rd_ack <= 1'b0;
	end

	// Pops are single clocks with a gap, so o_buf_empty is always fresh
	always @(posedge clk) begin
		if (i_rst || i_buf_rd_en)
			i_buf_rd_en <= 1'b0;
		else
			i_buf_rd_en <= !o_buf_empty && (($urandom % 100) < duty);
	end

	// Compare each popped word and each command, count done pulses
	always @(negedge clk) begin
		if (!i_rst && i_buf_rd_en) begin
			if (exp_ptr_q.size() == 0)
				report_failure("back buffer word popped with no frame pending");
			check_word(o_buf_dout, expected_word(exp_ptr_q[0], word_idx));
			if (word_idx == FRAME_WORDS - 1) begin
				void'(exp_ptr_q.pop_front());
				word_idx = 0;
			end else begin
				word_idx++;
			end
		end
		if (!i_rst && o_frame_done)
			done_count++;
		if (!i_rst && o_cmd_en && !o_reading)
			report_failure("read command issued without an arbiter grant");
		if (!i_rst && o_cmd_en) begin
			if (cmd_idx >= FRAME_WORDS / `FR_BURST_LEN)
				report_failure("more read commands issued than bursts in the frame");
			check_cmd(o_cmd, expected_cmd(cmd_ptr, cmd_idx));
			cmd_idx++;
		end
	end

	// --------------------
	// Sequence
	// --------------------
	task automatic run_frame(input frame_ptr_t wr_ptr, input frame_ptr_t depth);
		@(posedge clk);
		if (done_count != frames_started)
			report_failure("o_frame_done did not pulse exactly once for the last frame");
		i_wr_frame_ptr <= wr_ptr;
		i_frame_depth  <= depth;
		i_start_frame  <= 1'b1;
		exp_ptr_q.push_back(expected_ptr(wr_ptr, depth));
		cmd_ptr = expected_ptr(wr_ptr, depth);
		cmd_idx = 0;
		frames_started++;
		@(negedge clk);
		check_flag("o_rd_req", o_rd_req, 1'b0);   // Strobe not taken yet
		@(posedge clk);
		i_start_frame <= 1'b0;
		@(negedge clk);
		check_flag("o_rd_req", o_rd_req, 1'b1);
		check_ptr(o_rd_frame_ptr, expected_ptr(wr_ptr, depth));
	endtask

	// Returns one clock into DONE, the next clock finds the FSM in IDLE
	task automatic wait_frame_done();
		int n;
		n = 0;
		@(negedge clk);
		while (!o_frame_done) begin
			n++;
			if (n > WAIT_LIMIT)
				report_failure("timeout waiting for o_frame_done");
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	// Port holds data but the mover stops popping
	task automatic wait_backpressure();
		int n;
		n = 0;
		@(negedge clk);
		while (i_port_rd.empty || o_port_rd_en) begin
			n++;
			if (n > WAIT_LIMIT)
				report_failure("timeout waiting for the back buffer to reach prog full");
			@(negedge clk);
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		@(posedge clk);
		while (exp_ptr_q.size() != 0) begin
			n++;
			if (n > WAIT_LIMIT)
				report_failure("timeout waiting for the consumer to drain all frames");
			@(posedge clk);
		end
	endtask

	initial begin
		void'($urandom(32'h20fa5d4a));
		i_rst          = 1'b1;
		i_start_frame  = 1'b0;
		i_frame_depth  = '0;
		i_wr_frame_ptr = '0;
		i_frame_words  = 16'(FRAME_WORDS);
		i_calib_done   = 1'b0;
		i_rd_ack       = 1'b0;
		i_buf_rd_en    = 1'b0;
		word_idx       = 0;
		done_count     = 0;
		frames_started = 0;
		duty           = 75;
		cmd_ptr        = '0;
		cmd_idx        = 0;
		repeat (5) @(posedge clk);
		i_rst        <= 1'b0;
		i_calib_done <= 1'b1;
		@(negedge clk);
		check_flag("o_rd_req", o_rd_req, 1'b0);
		check_flag("o_reading", o_reading, 1'b0);
		check_flag("o_cmd_en", o_cmd_en, 1'b0);
		check_flag("o_buf_empty", o_buf_empty, 1'b1);

		run_frame(2'd0, 2'd3);                   // Wraps to frame 3
		wait_frame_done();
		run_frame(2'd2, 2'd3);                   // Back to back, buffer not drained
		wait_frame_done();
		run_frame(2'd1, 2'd2);
		duty = 5;                                // Slow consumer
		wait_backpressure();
		check_flag("o_buf_pe", o_buf_pe, 1'b0);
		duty = 75;
		wait_frame_done();
		run_frame(2'd0, 2'd1);
		wait_frame_done();
		run_frame(2'd3, 2'd3);
		wait_frame_done();
		wait_drained();
		@(negedge clk);
		check_flag("o_buf_empty", o_buf_empty, 1'b1);
		check_flag("o_buf_pe", o_buf_pe, 1'b1);
		@(posedge clk);
		if (done_count == frames_started && word_idx == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			report_failure("frame done count or word count wrong at end of run");
		end
	end

endmodule

/* testbench/tb_mem_port_model.sv */
/* Behavioral MCB read port for the testbench. Queues read commands and returns
   each burst word by word, every word equal to its own byte address.
   Random data gaps and random command-full stretch the latency. */
`timescale 1ns/1ps
`include "frame_rd_defines.svh"

module tb_mem_port_model import mem_port_pkg::*; (
	input  logic                      clk,
	input  logic                      i_rst,
	input  logic                      i_cmd_en,
	input  port_cmd_t                 i_cmd,
	input  logic                      i_rd_en,      // FWFT pop
	output logic                      o_cmd_full,
	output port_rd_t                  o_port_rd,
	output logic [`FR_DATA_WIDTH-1:0] o_data
);

	localparam int DW        = `FR_DATA_WIDTH;
	localparam int RD_DEPTH  = 64;   // Port read FIFO size
	localparam int CMD_SLOTS = 4;    // Port command FIFO size

	port_cmd_t     cmd_q [$];        // Accepted commands
	logic [DW-1:0] data_q [$];       // Read FIFO contents
	int            beat;             // Words returned for the head command
	port_rd_t      status;

	initial begin
		o_cmd_full      = 1'b0;
		o_port_rd       = '0;
		o_port_rd.empty = 1'b1;
		o_data          = '0;
		beat            = 0;
	end

	always @(posedge clk) begin
		if (i_rst) begin
			cmd_q.delete();
			data_q.delete();
			beat = 0;
		end else begin
			if (i_rd_en && data_q.size() > 0)
				void'(data_q.pop_front());   // Head leaves on the pop
			if (i_cmd_en)
				cmd_q.push_back(i_cmd);
			// One word per clock from the head burst, with gaps
			if (cmd_q.size() > 0 && data_q.size() < RD_DEPTH && ($urandom % 4) != 0) begin
				data_q.push_back(DW'(cmd_q[0].addr.byte_addr) + DW'(beat) * 4);
				beat++;
				if (beat == int'(cmd_q[0].bl) + 1) begin
					void'(cmd_q.pop_front());   // Burst complete
					beat = 0;
				end
			end
		end
		status       = '0;
		status.empty = (data_q.size() == 0);
		status.full  = (data_q.size() >= RD_DEPTH);
		o_port_rd  <= status;
		o_data     <= (data_q.size() > 0) ? data_q[0] : '0;
		o_cmd_full <= (cmd_q.size() >= CMD_SLOTS) || (($urandom % 5) == 0);
	end

endmodule

/* logic/frame_rd_top.sv */
/* Frame buffer read side: sequencer, counter, command generator, data mover
   and back buffer, wired to the arbiter, one MCB read port and the consumer. */
`timescale 1ns/1ps
`include "frame_rd_defines.svh"

module frame_rd_top import mem_port_pkg::*, frame_pkg::*; (
	input  logic                      clk,
	input  logic                      i_rst,
	// Control and arbiter
	input  logic                      i_start_frame,
	input  frame_ptr_t                i_frame_depth,
	input  frame_ptr_t                i_wr_frame_ptr,
	input  logic [15:0]               i_frame_words,
	input  logic                      i_calib_done,
	input  logic                      i_rd_ack,
	output logic                      o_rd_req,
	output logic                      o_reading,
	output frame_ptr_t                o_rd_frame_ptr,
	output logic                      o_frame_done,
	// MCB read port
	input  logic                      i_cmd_full,
	output logic                      o_cmd_en,
	output port_cmd_t                 o_cmd,
	input  port_rd_t                  i_port_rd,
	input  logic [`FR_DATA_WIDTH-1:0] i_port_data,
	output logic                      o_port_rd_en,
	// Consumer
	input  logic                      i_buf_rd_en,
	output buf_word_t                 o_buf_dout,
	output logic                      o_buf_empty,
	output logic                      o_buf_pe
);

	logic        frame_go;      // Launch strobe
	logic        words_done;    // Counter done pulse
	logic        cmd_issued;
	logic        word_moved;
	logic        bursts_left;
	logic        last_word;
	logic [15:0] burst_idx;     // Next burst word offset
	logic        buf_wr_en;
	buf_word_t   buf_din;
	logic        buf_pf;

	rd_frame_fsm u_fsm (
		.i_rst          (i_rst),
		.clk            (clk),
		.i_start_frame  (i_start_frame),
		.i_frame_depth  (i_frame_depth),
		.i_wr_frame_ptr (i_wr_frame_ptr),
		.i_rd_ack       (i_rd_ack),
		.i_calib_done   (i_calib_done),
		.i_words_done   (words_done),
		.o_rd_req       (o_rd_req),
		.o_reading      (o_reading),
		.o_rd_frame_ptr (o_rd_frame_ptr),
		.o_frame_go     (frame_go),
		.o_frame_done   (o_frame_done)
	);

	rd_burst_counter u_cnt (
		.i_rst         (i_rst),
		.clk           (clk),
		.i_frame_go    (frame_go),
		.i_frame_words (i_frame_words),
		.i_cmd_issued  (cmd_issued),
		.i_word_moved  (word_moved),
		.o_burst_idx   (burst_idx),
		.o_bursts_left (bursts_left),
		.o_last_word   (last_word),
		.o_words_done  (words_done)
	);

	rd_cmd_gen u_cmd (
		.i_rst          (i_rst),
		.clk            (clk),
		.i_frame_go     (frame_go),
		.i_rd_frame_ptr (o_rd_frame_ptr),
		.i_burst_idx    (burst_idx),
		.i_bursts_left  (bursts_left),
		.i_cmd_full     (i_cmd_full),
		.o_cmd_en       (o_cmd_en),
		.o_cmd          (o_cmd),
		.o_cmd_issued   (cmd_issued)
	);

	rd_data_mover u_mover (
		.i_rst        (i_rst),
		.clk          (clk),
		.i_port_rd    (i_port_rd),
		.i_port_data  (i_port_data),
		.i_buf_pf     (buf_pf),
		.i_last_word  (last_word),
		.o_port_rd_en (o_port_rd_en),
		.o_buf_wr_en  (buf_wr_en),
		.o_buf_din    (buf_din),
		.o_word_moved (word_moved)
	);

	back_fifo u_back_buf (
		.i_rst   (i_rst),
		.clk     (clk),
		.i_wr_en (buf_wr_en),
		.i_din   (buf_din),
		.i_rd_en (i_buf_rd_en),
		.o_dout  (o_buf_dout),
		.o_empty (o_buf_empty),
		.o_pe    (o_buf_pe),
		.o_pf    (buf_pf)
	);

endmodule

/* logic/back_fifo.sv */
/* Synchronous back buffer between the DDR3 read side and the image consumer.
   First-word-fall-through output, fill count drives the threshold flags. */
`timescale 1ns/1ps
`include "frame_rd_defines.svh"

module back_fifo import frame_pkg::*; (
	input  logic      i_rst,
	input  logic      clk,
	input  logic      i_wr_en,
	input  buf_word_t i_din,
	input  logic      i_rd_en,    // Pop, only while not empty
	output buf_word_t o_dout,     // Head word, valid when not empty
	output logic      o_empty,
	output logic      o_pe,       // At or below prog empty
	output logic      o_pf        // At or above prog full
);

	localparam int AW = $clog2(`FR_FIFO_DEPTH);

	buf_word_t     mem [`FR_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;      // Fill level, 0..DEPTH
	logic          full;
	logic          do_wr;
	logic          do_rd;

	assign full  = (count == (AW+1)'(`FR_FIFO_DEPTH));
	assign do_wr = i_wr_en & ~full;
	assign do_rd = i_rd_en & ~o_empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= i_din;
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or none
			endcase
		end
	end

	assign o_dout  = mem[rd_ptr];
	assign o_empty = (count == '0);
	assign o_pe    = (count <= (AW+1)'(`FR_FIFO_PE));
	assign o_pf    = (count >= (AW+1)'(`FR_FIFO_PF));

	// Prog full margin must cover the mover's pipeline
	assert property (@(posedge clk) disable iff (i_rst) i_wr_en |-> !full);
	// Consumer pops on not-empty only
	assert property (@(posedge clk) disable iff (i_rst) i_rd_en |-> !o_empty);

endmodule

/* logic/rd_data_mover.sv */
/* Moves words from the port read FIFO into the back buffer. Pops whenever
   data is there and the buffer is below prog full, tags the frame's last word. */
`timescale 1ns/1ps
`include "frame_rd_defines.svh"

module rd_data_mover import mem_port_pkg::*, frame_pkg::*; (
	input  logic                      i_rst,
	input  logic                      clk,
	input  port_rd_t                  i_port_rd,     // Port read FIFO status
	input  logic [`FR_DATA_WIDTH-1:0] i_port_data,   // FWFT data
	input  logic                      i_buf_pf,      // Back buffer prog full
	input  logic                      i_last_word,   // From the counter
	output logic                      o_port_rd_en,
	output logic                      o_buf_wr_en,
	output buf_word_t                 o_buf_din,
	output logic                      o_word_moved   // Strobe to the counter
);

	// Pop and count in the same cycle so the tag tracks back-to-back pops
	assign o_port_rd_en = ~i_port_rd.empty & ~i_buf_pf;
	assign o_word_moved = o_port_rd_en;

	always_ff @(posedge clk) begin
		if (i_rst)
			o_buf_wr_en <= 1'b0;
		else
			o_buf_wr_en <= o_port_rd_en;   // One clock after the pop
	end

	always_ff @(posedge clk) begin
		if (o_port_rd_en) begin
			o_buf_din.eof  <= i_last_word;
			o_buf_din.data <= i_port_data;
		end
	end

	// --------------------
	// Port health
	// --------------------
	assert property (@(posedge clk) disable iff (i_rst) !i_port_rd.overflow);
	assert property (@(posedge clk) disable iff (i_rst) !i_port_rd.error);

endmodule

/* logic/rd_cmd_gen.sv */
/* Burst read command issue to the MCB read port. Builds the byte address from
   the frame and the burst offset and holds a command until the port has room. */
`timescale 1ns/1ps
`include "frame_rd_defines.svh"

module rd_cmd_gen import mem_port_pkg::*, frame_pkg::*; (
	input  logic        i_rst,
	input  logic        clk,
	input  logic        i_frame_go,      // Latch the frame
	input  frame_ptr_t  i_rd_frame_ptr,
	input  logic [15:0] i_burst_idx,     // Word offset of this burst
	input  logic        i_bursts_left,
	input  logic        i_cmd_full,      // Port command FIFO full
	output logic        o_cmd_en,
	output port_cmd_t   o_cmd,
	output logic        o_cmd_issued     // Strobe to the counter
);

	localparam int ALIGN_W = $clog2(`FR_BURST_LEN) + 2;   // Byte bits inside a burst

	frame_ptr_t ptr_q;      // Frame of the running read
	logic       cmd_pend;   // Command built, waiting for room
	logic       load;
	cmd_addr_u  addr_n;

	always_comb begin
		addr_n.f.zero     = '0;
		addr_n.f.frame    = ptr_q;
		addr_n.f.word_off = WOFF_W'(i_burst_idx);
		addr_n.f.lane     = 2'b00;
	end

	// New command only once the counter has seen the last one
	assign load     = !cmd_pend && !o_cmd_issued && !i_frame_go && i_bursts_left;
	assign o_cmd_en = cmd_pend & ~i_cmd_full;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			cmd_pend     <= 1'b0;
			o_cmd_issued <= 1'b0;
		end else begin
			o_cmd_issued <= o_cmd_en;
			if (o_cmd_en)
				cmd_pend <= 1'b0;
			else if (load)
				cmd_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_frame_go)
			ptr_q <= i_rd_frame_ptr;
		if (load) begin
			o_cmd.instr <= CMD_READ;
			o_cmd.bl    <= 6'(`FR_BURST_LEN - 1);
			o_cmd.addr  <= addr_n;
		end
	end

	// Port sees whole bursts only
	assert property (@(posedge clk) disable iff (i_rst)
		o_cmd_en |-> o_cmd.addr.byte_addr[ALIGN_W-1:0] == '0);

endmodule

/* logic/rd_burst_counter.sv */
/* Burst and word bookkeeping for one frame. Loaded at frame launch, counts
   commands out and words moved, reports the next burst offset and the last word. */
`timescale 1ns/1ps
`include "frame_rd_defines.svh"

module rd_burst_counter (
	input  logic        i_rst,
	input  logic        clk,
	input  logic        i_frame_go,      // Load strobe
	input  logic [15:0] i_frame_words,   // Words per frame, multiple of burst
	input  logic        i_cmd_issued,    // One command accepted
	input  logic        i_word_moved,    // One word popped from the port
	output logic [15:0] o_burst_idx,     // Word offset of next burst
	output logic        o_bursts_left,
	output logic        o_last_word,     // Next word moved ends the frame
	output logic        o_words_done     // Pulse after the last word
);

	localparam int BL_SHIFT = $clog2(`FR_BURST_LEN);

	logic [15-BL_SHIFT:0] burst_cnt;   // Commands still to issue
	logic [15:0]          word_cnt;    // Words still to move

	always_ff @(posedge clk) begin
		if (i_rst) begin
			burst_cnt    <= '0;
			word_cnt     <= '0;
			o_burst_idx  <= '0;
			o_words_done <= 1'b0;
		end else begin
			o_words_done <= i_word_moved && (word_cnt == 16'd1);
			if (i_frame_go) begin
				burst_cnt   <= i_frame_words[15:BL_SHIFT];
				word_cnt    <= i_frame_words;
				o_burst_idx <= '0;
			end else begin
				if (i_cmd_issued) begin
					burst_cnt   <= burst_cnt - 1'b1;
					o_burst_idx <= o_burst_idx + 16'(`FR_BURST_LEN);   // Next block
				end
				if (i_word_moved)
					word_cnt <= word_cnt - 1'b1;
			end
		end
	end

	assign o_bursts_left = (burst_cnt != '0);
	assign o_last_word   = (word_cnt == 16'd1);

	// Port returns no more data than was asked for
	assert property (@(posedge clk) disable iff (i_rst) i_word_moved |-> word_cnt != '0);

endmodule

/* logic/rd_frame_fsm.sv */
/* Frame read sequencer. On a start strobe it picks the frame behind the writer,
   holds the arbiter request until granted, launches the frame and waits for the
   word counter before pulsing frame done. */
`timescale 1ns/1ps

module rd_frame_fsm import frame_pkg::*; (
	input  logic       i_rst,
	input  logic       clk,
	input  logic       i_start_frame,   // Strobe, taken in IDLE only
	input  frame_ptr_t i_frame_depth,   // Highest frame index
	input  frame_ptr_t i_wr_frame_ptr,  // Frame the writer is on
	input  logic       i_rd_ack,        // Arbiter grant, level
	input  logic       i_calib_done,    // DDR3 calibration done
	input  logic       i_words_done,    // All words of the frame moved
	output logic       o_rd_req,        // Arbiter request, level
	output logic       o_reading,       // High in RUN and DRAIN
	output frame_ptr_t o_rd_frame_ptr,  // Frame being read
	output logic       o_frame_go,      // Launch strobe to counter and cmd gen
	output logic       o_frame_done     // One pulse per frame
);

	rd_state_e  state;
	frame_ptr_t rd_ptr_n;   // Writer minus one, wrapped

	assign rd_ptr_n = (i_wr_frame_ptr == '0) ? i_frame_depth : i_wr_frame_ptr - 1'b1;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state          <= IDLE;
			o_rd_req       <= 1'b0;
			o_reading      <= 1'b0;
			o_rd_frame_ptr <= '0;
			o_frame_go     <= 1'b0;
			o_frame_done   <= 1'b0;
		end else begin
			o_frame_go   <= 1'b0;   // Strobes default low
			o_frame_done <= 1'b0;
			case (state)
				IDLE: begin
					if (i_start_frame && i_calib_done) begin
						o_rd_frame_ptr <= rd_ptr_n;   // Latched on leaving IDLE
						o_rd_req       <= 1'b1;
						state          <= REQ;
					end
				end
				REQ: begin
					if (i_rd_ack) begin
						o_rd_req   <= 1'b0;    // Grant seen, drop request
						o_reading  <= 1'b1;
						o_frame_go <= 1'b1;
						state      <= RUN;
					end
				end
				RUN: begin
					if (i_words_done) begin
						o_frame_done <= 1'b1;
						state        <= DRAIN;
					end
				end
				DRAIN: begin
					o_reading <= 1'b0;      // Release the memory
					state     <= DONE;
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// --------------------
	// Checks
	// --------------------
	// Request may only open a REQ window
	assert property (@(posedge clk) disable iff (i_rst) $rose(o_rd_req) |-> state == REQ);

endmodule

/* logic/frame_pkg.sv */
/* Types of the frame side: pointer, back buffer word and sequencer states.
   Imported by the sequencer, the mover, the back buffer and the top level. */
`include "frame_rd_defines.svh"

package frame_pkg;

	typedef logic [`FR_PTR_WIDTH-1:0] frame_ptr_t;   // Frame index

	// One back buffer entry, 33 bits with the default width
	typedef struct packed {
		logic                      eof;   // Last word of the frame
		logic [`FR_DATA_WIDTH-1:0] data;  // Pixel data from DDR3
	} buf_word_t;

	typedef enum logic [2:0] {
		IDLE,    // Waiting for calibration and start
		REQ,     // Arbiter request held
		RUN,     // Frame in flight
		DRAIN,   // Last word landing, done pulsed
		DONE     // Grant released, back to IDLE
	} rd_state_e;

endpackage

/* logic/mem_port_pkg.sv */
/* Types of the MCB user port as seen from the read side.
   Imported by the command generator, the data mover and the top level. */
`include "frame_rd_defines.svh"

package mem_port_pkg;

	localparam int ADDR_W     = 30;                                      // MCB byte address
	localparam int WOFF_W     = `FR_FRAME_SHIFT - 2;                     // Word offset in frame
	localparam int ADDR_PAD_W = ADDR_W - `FR_FRAME_SHIFT - `FR_PTR_WIDTH; // Unused top bits

	typedef enum logic [2:0] {
		CMD_WRITE = 3'd0,          // Plain write
		CMD_READ  = 3'd1           // Plain read, the only one issued here
	} cmd_instr_e;

	// Field view, as the command generator builds it
	typedef struct packed {
		logic [ADDR_PAD_W-1:0]    zero;     // Always zero
		logic [`FR_PTR_WIDTH-1:0] frame;    // Frame index
		logic [WOFF_W-1:0]        word_off; // Word offset in the frame
		logic [1:0]               lane;     // Byte lane, zero for word access
	} cmd_addr_f_t;

	typedef union packed {
		logic [ADDR_W-1:0] byte_addr;       // Flat view taken by the port
		cmd_addr_f_t       f;
	} cmd_addr_u;

	typedef struct packed {
		cmd_instr_e instr;
		logic [5:0] bl;                     // Burst length minus one
		cmd_addr_u  addr;
	} port_cmd_t;

	typedef struct packed {
		logic empty;                        // Read FIFO empty
		logic full;                         // Read FIFO full
		logic overflow;                     // Data lost in the port
		logic error;                        // Port pointer error
	} port_rd_t;

endpackage

/* logic/frame_rd_defines.svh */
/* Build-time sizes for the frame buffer read side.
   Included by both packages and by every module that sizes a port or a FIFO. */
`ifndef FRAME_RD_DEFINES_SVH
`define FRAME_RD_DEFINES_SVH

// --------------------
// Memory port
// --------------------
`define FR_DATA_WIDTH   32  // MCB user port data width
`define FR_BURST_LEN    16  // Words per read command

// --------------------
// Frame layout
// --------------------
`define FR_PTR_WIDTH    2   // Up to 4 frames
`define FR_FRAME_SHIFT  23  // Frame base = ptr << 23, 8 MB per frame

// --------------------
// Back buffer
// --------------------
`define FR_FIFO_DEPTH   64  // Power of two
`define FR_FIFO_PF      48  // Prog full, stops popping the port
`define FR_FIFO_PE      4   // Prog empty, hint to the consumer

`endif
